//--- uart_pkg.sv
`default_nettype none

package uart_pkg;

    typedef logic [7:0]  uart_data_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [5:0]  reg_addr_t;   // Word address, bits 7:2
    typedef logic [23:0] baud_div_t;   // Clocks per bit

    // Odd/even count the ones over data plus parity bit
    typedef enum logic [2:0] {
        PARITY_OFF  = 3'd0,
        PARITY_ODD  = 3'd1,
        PARITY_EVEN = 3'd2,
        PARITY_ZERO = 3'd4,
        PARITY_ONE  = 3'd5
    } parity_mode_t;

    // Same layout as the CFG register
    typedef struct packed {
        logic [3:0]   spare;
        logic         two_stop;
        parity_mode_t parity;
        baud_div_t    divisor;
    } uart_cfg_t;

    typedef enum logic [2:0] {
        FRAME_IDLE,
        FRAME_START,
        FRAME_DATA,
        FRAME_PARITY,
        FRAME_STOP1,
        FRAME_STOP2,
        FRAME_DONE
    } frame_state_t;

    localparam reg_addr_t ADDR_TX   = 6'd0;
    localparam reg_addr_t ADDR_RX   = 6'd1;
    localparam reg_addr_t ADDR_CFG  = 6'd2;
    localparam reg_addr_t ADDR_STAT = 6'd3;

    // STAT bit positions
    localparam int STAT_RX_AVAIL   = 0;
    localparam int STAT_TX_SPACE   = 1;
    localparam int STAT_PARITY_ERR = 2;

    localparam int FIFO_DEPTH = 16;

endpackage

`default_nettype wire

//--- uart_baud_gen.sv
`timescale 1ns/1ns
`default_nettype none

module uart_baud_gen #(
    parameter bit MID_BIT = 1'b0
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                en,
    input  uart_pkg::baud_div_t divisor,
    output logic                tick
);
    import uart_pkg::*;

    baud_div_t count;
    baud_div_t tick_at;

    // Counts 1..divisor, parked at 1 while disabled
    always_ff @(posedge clk) begin
        if (!rstn || !en) begin
            count <= baud_div_t'(1);
        end else if (count >= divisor) begin
            count <= baud_div_t'(1);
        end else begin
            count <= count + baud_div_t'(1);
        end
    end

    assign tick_at = MID_BIT ? (divisor >> 1) : baud_div_t'(1);   // Mid-bit for the receiver
    assign tick    = en && (count == tick_at);

endmodule

`default_nettype wire

//--- uart_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module uart_fifo #(
    parameter int DEPTH = uart_pkg::FIFO_DEPTH
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 wr,
    input  logic                 rd,
    input  uart_pkg::uart_data_t wr_data,
    output uart_pkg::uart_data_t rd_data,
    output logic                 full,
    output logic                 empty
);
    import uart_pkg::*;

    typedef logic [$clog2(DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(DEPTH):0]   cnt_t;

    uart_data_t mem [DEPTH];
    ptr_t       wr_ptr;
    ptr_t       rd_ptr;
    cnt_t       count;

    function automatic ptr_t ptr_next(input ptr_t p);
        return (p == ptr_t'(DEPTH - 1)) ? '0 : p + ptr_t'(1);
    endfunction

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) wr_ptr <= ptr_next(wr_ptr);
            if (rd) rd_ptr <= ptr_next(rd_ptr);
            case ({wr, rd})
                2'b10:   count <= count + cnt_t'(1);
                2'b01:   count <= count - cnt_t'(1);
                default: ;   // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr) mem[wr_ptr] <= wr_data;
        if (rd) rd_data <= mem[rd_ptr];   // Valid the cycle after rd
    end

    assign full  = count == cnt_t'(DEPTH);
    assign empty = count == '0;

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  logic                 clk,
    input  logic                 rstn,
    input  uart_pkg::uart_cfg_t  cfg,
    input  logic                 fifo_empty,
    input  uart_pkg::uart_data_t fifo_rd_data,
    output logic                 fifo_rd,
    input  logic                 tick,
    output logic                 bit_en,
    output logic                 tx
);
    import uart_pkg::*;

    frame_state_t state;
    logic [2:0]   bit_cnt;
    uart_data_t   shift;
    uart_data_t   hold_data;
    logic         hold_valid;
    logic         rd_pending;
    logic         par_en;
    logic         par_bit;
    logic         next_par_en;
    logic         next_par_bit;

    // Fetch one byte ahead into the holding register
    assign fifo_rd = !fifo_empty && !hold_valid && !rd_pending;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_pending <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            rd_pending <= fifo_rd;
            if (rd_pending) begin
                hold_valid <= 1'b1;
            end else if (state == FRAME_IDLE) begin
                hold_valid <= 1'b0;   // Taken by the shifter
            end
        end
    end

    always_comb begin
        next_par_en  = 1'b1;
        next_par_bit = 1'b0;
        case (cfg.parity)
            PARITY_ODD:  next_par_bit = ~^hold_data;
            PARITY_EVEN: next_par_bit = ^hold_data;
            PARITY_ZERO: next_par_bit = 1'b0;
            PARITY_ONE:  next_par_bit = 1'b1;
            default:     next_par_en  = 1'b0;   // Off and unused codes
        endcase
    end

    // Each state drives its bit on its tick
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= FRAME_IDLE;
            bit_cnt <= '0;
            tx      <= 1'b1;
        end else begin
            case (state)
                FRAME_IDLE: begin
                    tx <= 1'b1;
                    if (hold_valid) state <= FRAME_START;
                end
                FRAME_START: if (tick) begin
                    tx      <= 1'b0;
                    bit_cnt <= '0;
                    state   <= FRAME_DATA;
                end
                FRAME_DATA: if (tick) begin
                    tx      <= shift[0];   // LSB first
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) state <= par_en ? FRAME_PARITY : FRAME_STOP1;
                end
                FRAME_PARITY: if (tick) begin
                    tx    <= par_bit;
                    state <= FRAME_STOP1;
                end
                FRAME_STOP1: if (tick) begin
                    tx      <= 1'b1;
                    bit_cnt <= '0;
                    state   <= cfg.two_stop ? FRAME_STOP2 : FRAME_DONE;
                end
                FRAME_STOP2: if (tick) begin
                    tx    <= 1'b1;
                    state <= FRAME_DONE;
                end
                FRAME_DONE: if (tick) begin
                    // End of last stop bit, then one idle bit
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt[0]) state <= FRAME_IDLE;
                end
                default: state <= FRAME_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pending) hold_data <= fifo_rd_data;
        if (state == FRAME_IDLE && hold_valid) begin
            shift   <= hold_data;
            par_en  <= next_par_en;
            par_bit <= next_par_bit;
        end else if (state == FRAME_DATA && tick) begin
            shift <= shift >> 1;
        end
    end

    assign bit_en = state != FRAME_IDLE;

endmodule

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  logic                 clk,
    input  logic                 rstn,
    input  uart_pkg::uart_cfg_t  cfg,
    input  logic                 rx,
    input  logic                 tick,
    output logic                 bit_en,
    input  logic                 fifo_full,
    output logic                 fifo_wr,
    output uart_pkg::uart_data_t fifo_wr_data,
    input  logic                 parity_clear,
    output logic                 parity_error
);
    import uart_pkg::*;

    frame_state_t state;
    logic [2:0]   bit_cnt;
    uart_data_t   shift;
    logic         par_rx;
    logic         par_fail;
    logic         rx_meta;
    logic         rx_sync;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_comb begin
        case (cfg.parity)
            PARITY_OFF:  par_fail = 1'b0;
            PARITY_ODD:  par_fail = ~^{par_rx, shift};
            PARITY_EVEN: par_fail = ^{par_rx, shift};
            PARITY_ZERO: par_fail = par_rx;
            PARITY_ONE:  par_fail = ~par_rx;
            default:     par_fail = 1'b1;   // Unused codes always fail
        endcase
    end

    // Ticks land at mid-bit
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= FRAME_IDLE;
            bit_cnt      <= '0;
            parity_error <= 1'b0;
        end else begin
            case (state)
                FRAME_IDLE: if (!rx_sync) state <= FRAME_START;
                FRAME_START: if (tick) begin
                    bit_cnt <= '0;
                    state   <= rx_sync ? FRAME_IDLE : FRAME_DATA;   // Glitch rejected
                end
                FRAME_DATA: if (tick) begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        state <= (cfg.parity != PARITY_OFF) ? FRAME_PARITY : FRAME_STOP1;
                    end
                end
                FRAME_PARITY: if (tick) state <= FRAME_STOP1;
                FRAME_STOP1: if (tick) state <= cfg.two_stop ? FRAME_STOP2 : FRAME_DONE;
                FRAME_STOP2: if (tick) state <= FRAME_DONE;
                FRAME_DONE: state <= FRAME_IDLE;
                default: state <= FRAME_IDLE;
            endcase

            if (state == FRAME_DONE && par_fail) begin
                parity_error <= 1'b1;
            end else if (parity_clear) begin
                parity_error <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == FRAME_DATA && tick) shift <= {rx_sync, shift[7:1]};
        if (state == FRAME_PARITY && tick) par_rx <= rx_sync;
    end

    assign bit_en       = state != FRAME_IDLE;
    assign fifo_wr      = state == FRAME_DONE && !par_fail && !fifo_full;
    assign fifo_wr_data = shift;

endmodule

`default_nettype wire

//--- uart_axi_regs.sv
`timescale 1ns/1ns
`default_nettype none

module uart_axi_regs (
    input  logic                 clk,
    input  logic                 rstn,
    input  uart_pkg::axi_data_t  awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  uart_pkg::axi_data_t  wdata,
    input  uart_pkg::axi_strb_t  wstrb,
    input  logic                 wvalid,
    output logic                 wready,
    output logic                 bvalid,
    input  logic                 bready,
    input  uart_pkg::axi_data_t  araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output uart_pkg::axi_data_t  rdata,
    output logic                 rvalid,
    input  logic                 rready,
    output uart_pkg::uart_cfg_t  cfg,
    output logic                 tx_push,
    output uart_pkg::uart_data_t tx_push_data,
    input  logic                 tx_full,
    output logic                 rx_pop,
    input  uart_pkg::uart_data_t rx_pop_data,
    input  logic                 rx_empty,
    input  logic                 parity_error,
    output logic                 parity_clear
);
    import uart_pkg::*;

    typedef enum logic [2:0] {
        AXI_IDLE,
        AXI_WR_DATA,
        AXI_WR_RESP,
        AXI_RD_EXEC,
        AXI_RD_DATA,
        AXI_RD_BACK
    } axi_state_t;

    axi_state_t state;
    reg_addr_t  waddr;
    reg_addr_t  raddr;
    axi_data_t  wdata_q;
    axi_strb_t  wstrb_q;
    axi_data_t  rdata_q;
    axi_data_t  wmask;
    axi_data_t  stat;
    logic       rx_popped;
    logic       b_done;

    assign awready = state == AXI_IDLE;
    assign arready = state == AXI_IDLE && !awvalid;   // Write wins a tie
    assign wready  = state == AXI_WR_DATA;
    assign bvalid  = state == AXI_WR_RESP;
    assign rvalid  = state == AXI_RD_BACK;
    assign rdata   = rdata_q;

    assign wmask  = {{8{wstrb_q[3]}}, {8{wstrb_q[2]}}, {8{wstrb_q[1]}}, {8{wstrb_q[0]}}};
    assign b_done = bvalid && bready;

    // Side effects fire on the B handshake
    assign tx_push      = b_done && waddr == ADDR_TX && wstrb_q[0] && !tx_full;
    assign tx_push_data = wdata_q[7:0];
    assign parity_clear = b_done && waddr == ADDR_STAT && wstrb_q[0]
                          && wdata_q[STAT_PARITY_ERR];
    assign rx_pop       = state == AXI_RD_EXEC && raddr == ADDR_RX && !rx_empty;

    always_comb begin
        stat                  = '0;
        stat[STAT_RX_AVAIL]   = !rx_empty;
        stat[STAT_TX_SPACE]   = !tx_full;
        stat[STAT_PARITY_ERR] = parity_error;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= AXI_IDLE;
            cfg       <= '0;
            rx_popped <= 1'b0;
        end else begin
            case (state)
                AXI_IDLE: begin
                    if (awvalid) begin
                        state <= AXI_WR_DATA;
                    end else if (arvalid) begin
                        state <= AXI_RD_EXEC;
                    end
                end
                AXI_WR_DATA: if (wvalid) state <= AXI_WR_RESP;
                AXI_WR_RESP: if (bready) begin
                    state <= AXI_IDLE;
                    if (waddr == ADDR_CFG) begin
                        cfg <= uart_cfg_t'((wdata_q & wmask) | (axi_data_t'(cfg) & ~wmask));
                    end
                end
                AXI_RD_EXEC: begin
                    rx_popped <= rx_pop;
                    state     <= AXI_RD_DATA;
                end
                AXI_RD_DATA: state <= AXI_RD_BACK;   // FIFO data valid now
                AXI_RD_BACK: if (rready) state <= AXI_IDLE;
                default: state <= AXI_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (awready && awvalid) waddr <= awaddr[7:2];
        if (arready && arvalid) raddr <= araddr[7:2];
        if (wready && wvalid) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (state == AXI_RD_DATA) begin
            case (raddr)
                ADDR_RX:   rdata_q <= rx_popped ? axi_data_t'(rx_pop_data) : '0;
                ADDR_CFG:  rdata_q <= axi_data_t'(cfg);
                ADDR_STAT: rdata_q <= stat;
                default:   rdata_q <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- uart_axi.sv
`timescale 1ns/1ns
`default_nettype none

module uart_axi (
    input  logic                clk,
    input  logic                rstn,
    input  uart_pkg::axi_data_t awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  uart_pkg::axi_data_t wdata,
    input  uart_pkg::axi_strb_t wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  uart_pkg::axi_data_t araddr,
    input  logic                arvalid,
    output logic                arready,
    output uart_pkg::axi_data_t rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,
    input  logic                rx,
    output logic                tx
);
    import uart_pkg::*;

    uart_cfg_t  cfg;
    uart_data_t tx_push_data;
    uart_data_t tx_rd_data;
    uart_data_t rx_pop_data;
    uart_data_t rx_wr_data;
    logic       tx_push;
    logic       tx_full;
    logic       tx_empty;
    logic       tx_rd;
    logic       rx_pop;
    logic       rx_full;
    logic       rx_empty;
    logic       rx_wr;
    logic       parity_error;
    logic       parity_clear;
    logic       tx_bit_en;
    logic       tx_tick;
    logic       rx_bit_en;
    logic       rx_tick;

    assign bresp = 2'b00;   // OKAY only
    assign rresp = 2'b00;

    uart_axi_regs regs (
        .clk(clk), .rstn(rstn),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready),
        .cfg(cfg),
        .tx_push(tx_push), .tx_push_data(tx_push_data), .tx_full(tx_full),
        .rx_pop(rx_pop), .rx_pop_data(rx_pop_data), .rx_empty(rx_empty),
        .parity_error(parity_error), .parity_clear(parity_clear)
    );

    uart_fifo #(.DEPTH(FIFO_DEPTH)) tx_fifo (
        .clk(clk), .rstn(rstn),
        .wr(tx_push), .rd(tx_rd), .wr_data(tx_push_data), .rd_data(tx_rd_data),
        .full(tx_full), .empty(tx_empty)
    );

    uart_fifo #(.DEPTH(FIFO_DEPTH)) rx_fifo (
        .clk(clk), .rstn(rstn),
        .wr(rx_wr), .rd(rx_pop), .wr_data(rx_wr_data), .rd_data(rx_pop_data),
        .full(rx_full), .empty(rx_empty)
    );

    uart_tx u_tx (
        .clk(clk), .rstn(rstn), .cfg(cfg),
        .fifo_empty(tx_empty), .fifo_rd_data(tx_rd_data), .fifo_rd(tx_rd),
        .tick(tx_tick), .bit_en(tx_bit_en), .tx(tx)
    );

    uart_rx u_rx (
        .clk(clk), .rstn(rstn), .cfg(cfg), .rx(rx),
        .tick(rx_tick), .bit_en(rx_bit_en),
        .fifo_full(rx_full), .fifo_wr(rx_wr), .fifo_wr_data(rx_wr_data),
        .parity_clear(parity_clear), .parity_error(parity_error)
    );

    uart_baud_gen #(.MID_BIT(1'b0)) tx_baud (
        .clk(clk), .rstn(rstn), .en(tx_bit_en), .divisor(cfg.divisor), .tick(tx_tick)
    );

    // Receiver samples in the middle of each bit
    uart_baud_gen #(.MID_BIT(1'b1)) rx_baud (
        .clk(clk), .rstn(rstn), .en(rx_bit_en), .divisor(cfg.divisor), .tick(rx_tick)
    );

endmodule

`default_nettype wire

//--- uart_axi_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module uart_axi_assertions (
    input logic                clk,
    input logic                rstn,
    input logic                awready,
    input logic                bvalid,
    input logic                rvalid,
    input logic                rready,
    input uart_pkg::axi_data_t rdata,
    input logic                tx_push,
    input logic                tx_full,
    input logic                tx_rd,
    input logic                tx_empty,
    input logic                rx_wr,
    input logic                rx_full,
    input logic                rx_pop,
    input logic                rx_empty
);

    // Responses only outside idle
    a_resp_not_idle: assert property (@(posedge clk) disable iff (!rstn)
        !((bvalid || rvalid) && awready))
        else $error("response valid while awready is high");

    a_rdata_stable: assert property (@(posedge clk) disable iff (!rstn)
        rvalid && !rready |=> $stable(rdata))
        else $error("rdata changed while stalled");

    a_tx_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        !(tx_push && tx_full))
        else $error("TX FIFO written while full");

    a_tx_no_underflow: assert property (@(posedge clk) disable iff (!rstn)
        !(tx_rd && tx_empty))
        else $error("TX FIFO read while empty");

    a_rx_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        !(rx_wr && rx_full))
        else $error("RX FIFO written while full");

    a_rx_no_underflow: assert property (@(posedge clk) disable iff (!rstn)
        !(rx_pop && rx_empty))
        else $error("RX FIFO read while empty");

endmodule

`default_nettype wire

//--- tb_uart_axi.sv
`timescale 1ns/1ns
`default_nettype none

module tb_uart_axi;
    import uart_pkg::*;

    localparam int DIV     = 8;      // Clocks per serial bit
    localparam int TIMEOUT = 2000;

    logic       clk;
    logic       rstn;
    axi_data_t  awaddr;
    logic       awvalid;
    logic       awready;
    axi_data_t  wdata;
    axi_strb_t  wstrb;
    logic       wvalid;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;
    axi_data_t  araddr;
    logic       arvalid;
    logic       arready;
    axi_data_t  rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       rready;
    logic       rx;
    logic       tx;
    integer     seed;
    int         errors;

    uart_axi DUT (.*);

    bind uart_axi uart_axi_assertions u_assertions (
        .clk(clk), .rstn(rstn),
        .awready(awready), .bvalid(bvalid), .rvalid(rvalid), .rready(rready), .rdata(rdata),
        .tx_push(tx_push), .tx_full(tx_full), .tx_rd(tx_rd), .tx_empty(tx_empty),
        .rx_wr(rx_wr), .rx_full(rx_full), .rx_pop(rx_pop), .rx_empty(rx_empty)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("CHECKS FAILED");
        $fatal(1, "%s", what);
    endtask

    task automatic check_eq(input axi_data_t actual, input axi_data_t expected,
                            input string what);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "%s", what);
        end
    endtask

    // Parity bit that makes the count of ones odd or even
    function automatic logic parity_for(input uart_data_t data, input parity_mode_t mode);
        int ones;
        ones = 0;
        for (int i = 0; i < 8; i++) ones += int'(data[i]);
        case (mode)
            PARITY_ODD:  return (ones % 2) == 0;
            PARITY_EVEN: return (ones % 2) == 1;
            PARITY_ZERO: return 1'b0;
            default:     return 1'b1;
        endcase
    endfunction

    function automatic axi_data_t make_cfg(input parity_mode_t mode, input logic two_stop);
        return {4'h0, two_stop, mode, baud_div_t'(DIV)};
    endfunction

    task automatic axi_write(input reg_addr_t addr, input axi_data_t data, input axi_strb_t strb);
        int n;
        @(negedge clk);
        awaddr  = {24'h0, addr, 2'b00};
        awvalid = 1'b1;
        n = 0;
        while (!awready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run("awready never went high");
        end
        @(negedge clk);
        awvalid = 1'b0;
        wdata   = data;
        wstrb   = strb;
        wvalid  = 1'b1;
        n = 0;
        while (!wready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run("wready never went high");
        end
        @(negedge clk);
        wvalid = 1'b0;
        bready = 1'b1;
        n = 0;
        while (!bvalid) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run("bvalid never went high");
        end
        check_eq(32'(bresp), 32'd0, "bresp is OKAY");
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input reg_addr_t addr, output axi_data_t data);
        int n;
        @(negedge clk);
        araddr  = {24'h0, addr, 2'b00};
        arvalid = 1'b1;
        n = 0;
        while (!arready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run("arready never went high");
        end
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run("rvalid never went high");
        end
        data = rdata;
        check_eq(32'(rresp), 32'd0, "rresp is OKAY");
        @(negedge clk);   // One stalled cycle with rready low
        check_eq(32'(rvalid), 32'd1, "rvalid held while rready low");
        check_eq(rdata, data, "rdata held while rready low");
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic wait_stat_bit(input int pos);
        axi_data_t v;
        int        n;
        n = 0;
        axi_read(ADDR_STAT, v);
        while (!v[pos]) begin
            n++;
            if (n > TIMEOUT) abort_run("STAT flag never got set");
            axi_read(ADDR_STAT, v);
        end
    endtask

    // Start bit, data LSB first, optional parity, stop bit plus one idle bit
    task automatic send_serial(input uart_data_t data, input logic with_par, input logic par_bit);
        int i;
        @(negedge clk);
        rx = 1'b0;
        repeat (DIV) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            rx = data[i];
            repeat (DIV) @(negedge clk);
        end
        if (with_par) begin
            rx = par_bit;
            repeat (DIV) @(negedge clk);
        end
        rx = 1'b1;
        repeat (2 * DIV) @(negedge clk);
    endtask

    task automatic recv_serial(input logic with_par, input int n_stop,
                               output uart_data_t data, output logic par_bit);
        int n;
        int i;
        data    = '0;
        par_bit = 1'b0;
        n = 0;
        @(negedge clk);
        while (tx !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run("no start bit seen on tx");
        end
        repeat (DIV / 2) @(negedge clk);   // Middle of the start bit
        check_eq(32'(tx), 32'd0, "tx start bit");
        for (i = 0; i < 8; i++) begin
            repeat (DIV) @(negedge clk);
            data[i] = tx;
        end
        if (with_par) begin
            repeat (DIV) @(negedge clk);
            par_bit = tx;
        end
        for (i = 0; i < n_stop; i++) begin
            repeat (DIV) @(negedge clk);
            check_eq(32'(tx), 32'd1, "tx stop bit");
        end
    endtask

    task automatic regs_after_reset();
        axi_data_t v;
        axi_read(ADDR_STAT, v);
        check_eq(v, 32'h2, "STAT after reset");
        axi_read(ADDR_CFG, v);
        check_eq(v, 32'h0, "CFG after reset");
        axi_write(ADDR_CFG, 32'hA500_0008, 4'hF);
        axi_read(ADDR_CFG, v);
        check_eq(v, 32'hA500_0008, "CFG full write");
        axi_write(ADDR_CFG, 32'hFFFF_FFFF, 4'b0010);
        axi_read(ADDR_CFG, v);
        check_eq(v, 32'hA500_FF08, "CFG write of byte 1 only");
    endtask

    task automatic tx_framing();
        uart_data_t bytes [3];
        uart_data_t got;
        logic       par;
        int         i;
        int         j;
        int         k;
        axi_write(ADDR_CFG, make_cfg(PARITY_OFF, 1'b0), 4'hF);
        for (i = 0; i < 3; i++) bytes[i] = 8'($random(seed));
        fork
            begin
                for (j = 0; j < 3; j++) axi_write(ADDR_TX, 32'(bytes[j]), 4'h1);
            end
            begin
                for (k = 0; k < 3; k++) begin
                    recv_serial(1'b0, 1, got, par);
                    check_eq(32'(got), 32'(bytes[k]), "tx byte, parity off");
                end
            end
        join
    endtask

    task automatic tx_parity_stop();
        parity_mode_t modes [4];
        uart_data_t   data;
        uart_data_t   got;
        logic         par;
        int           i;
        modes = '{PARITY_ODD, PARITY_EVEN, PARITY_ZERO, PARITY_ONE};
        for (i = 0; i < 4; i++) begin
            data = 8'($random(seed));
            axi_write(ADDR_CFG, make_cfg(modes[i], 1'b1), 4'hF);
            fork
                axi_write(ADDR_TX, 32'(data), 4'h1);
                recv_serial(1'b1, 2, got, par);
            join
            check_eq(32'(got), 32'(data), "tx byte with parity");
            check_eq(32'(par), 32'(parity_for(data, modes[i])), "tx parity bit");
        end
    endtask

    task automatic rx_path(input parity_mode_t mode);
        uart_data_t bytes [3];
        axi_data_t  v;
        int         i;
        axi_write(ADDR_CFG, make_cfg(mode, 1'b0), 4'hF);
        for (i = 0; i < 3; i++) begin
            bytes[i] = 8'($random(seed));
            send_serial(bytes[i], mode != PARITY_OFF, parity_for(bytes[i], mode));
        end
        wait_stat_bit(STAT_RX_AVAIL);
        for (i = 0; i < 3; i++) begin
            axi_read(ADDR_RX, v);
            check_eq(v, 32'(bytes[i]), "rx byte");
        end
        axi_read(ADDR_STAT, v);
        check_eq(32'(v[STAT_RX_AVAIL]), 32'd0, "STAT rx data after drain");
        axi_read(ADDR_RX, v);
        check_eq(v, 32'h0, "RX read while empty");
    endtask

    task automatic parity_error_flag();
        uart_data_t bad;
        uart_data_t good;
        axi_data_t  v;
        axi_write(ADDR_CFG, make_cfg(PARITY_ODD, 1'b0), 4'hF);
        bad = 8'($random(seed));
        send_serial(bad, 1'b1, !parity_for(bad, PARITY_ODD));
        wait_stat_bit(STAT_PARITY_ERR);
        axi_read(ADDR_STAT, v);
        check_eq(v, 32'h6, "STAT after bad parity frame");   // Frame dropped
        good = 8'($random(seed));
        send_serial(good, 1'b1, parity_for(good, PARITY_ODD));
        wait_stat_bit(STAT_RX_AVAIL);
        axi_read(ADDR_RX, v);
        check_eq(v, 32'(good), "rx byte after parity error");
        axi_write(ADDR_STAT, 32'h4, 4'h1);
        axi_read(ADDR_STAT, v);
        check_eq(v, 32'h2, "STAT after parity clear");
    endtask

    initial begin
        seed    = 32'h3c0027ef;
        errors  = 0;
        rstn    = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        rx      = 1'b1;   // Line idle
        repeat (3) @(negedge clk);
        rstn = 1'b1;

        regs_after_reset();
        tx_framing();
        tx_parity_stop();
        rx_path(PARITY_OFF);
        rx_path(PARITY_EVEN);
        parity_error_flag();

        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
uart_pkg.sv
uart_baud_gen.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_axi_regs.sv
uart_axi.sv
uart_axi_assertions.sv
tb_uart_axi.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_uart_axi
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o $(TOP)

# The simulation output is searched for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
